// ==== src/riscv_dcache_pkg.sv ====
package riscv_dcache_pkg;

  // width of one cache line in bits
  localparam int LINE_BITS = 128;

  // one cache line, seen as bytes for store merge and as doublewords for loads
  typedef union packed {
    logic [LINE_BITS/8-1:0][7:0]   bytes;
    logic [LINE_BITS/64-1:0][63:0] dwords;
  } line_u;

  typedef enum logic [1:0] {
    SIZE_BYTE  = 2'b00,
    SIZE_HALF  = 2'b01,
    SIZE_WORD  = 2'b10,
    SIZE_DWORD = 2'b11
  } store_size_e;

  // funct5 codes of the A extension
  typedef enum logic [4:0] {
    AMO_ADD  = 5'b00000,
    AMO_SWAP = 5'b00001,
    AMO_XOR  = 5'b00100,
    AMO_OR   = 5'b01000,
    AMO_AND  = 5'b01100,
    AMO_MIN  = 5'b10000,
    AMO_MAX  = 5'b10100,
    AMO_MINU = 5'b11000,
    AMO_MAXU = 5'b11100
  } amo_op_e;

  typedef enum logic [2:0] {
    IDLE,
    WRITE_BACK,
    REFILL,
    AMO_READ,
    AMO_WRITE
  } dcache_state_e;

endpackage

// ==== src/riscv_dcache_mem_if.sv ====
`timescale 1ns/1ps

interface riscv_dcache_mem_if #(
  parameter int ADDR_W = 10
);
  import riscv_dcache_pkg::*;

  // request side
  logic              mem_wren;
  logic              mem_rden;
  logic [ADDR_W-1:0] mem_addr;
  line_u             mem_wdata;
  // response side
  line_u             mem_rdata;
  logic              mem_ready;

  modport cache (
    output mem_wren,
    output mem_rden,
    output mem_addr,
    output mem_wdata,
    input  mem_rdata,
    input  mem_ready
  );

  modport memory (
    input  mem_wren,
    input  mem_rden,
    input  mem_addr,
    input  mem_wdata,
    output mem_rdata,
    output mem_ready
  );

endinterface

// ==== src/riscv_dcache_tag.sv ====
`timescale 1ns/1ps

module riscv_dcache_tag #(
  parameter int INDEX = 6,
  parameter int TAG   = 4
) (
  input  logic             i_riscv_dcache_clk,
  input  logic             i_riscv_dcache_rst,
  input  logic [INDEX-1:0] i_index,
  input  logic [TAG-1:0]   i_tag,
  input  logic             i_set_valid,
  input  logic             i_set_dirty,
  input  logic             i_replace_tag,
  output logic             o_hit,
  output logic             o_dirty,
  output logic [TAG-1:0]   o_victim_tag
);

  localparam int DEPTH = 2 ** INDEX;

  logic [TAG-1:0]   tag_mem [DEPTH];
  logic [DEPTH-1:0] valid;
  logic [DEPTH-1:0] dirty;

  // lookup is combinational
  assign o_victim_tag = tag_mem[i_index];
  assign o_hit        = valid[i_index] && (tag_mem[i_index] == i_tag);
  assign o_dirty      = valid[i_index] && dirty[i_index];

  always_ff @(posedge i_riscv_dcache_clk)
  begin
    if (i_replace_tag)
      tag_mem[i_index] <= i_tag;
  end

  // status bits per set
  always_ff @(posedge i_riscv_dcache_clk or posedge i_riscv_dcache_rst)
  begin
    if (i_riscv_dcache_rst)
    begin
      valid <= '0;
      dirty <= '0;
    end
    else if (i_replace_tag)
    begin
      valid[i_index] <= i_set_valid;
      dirty[i_index] <= i_set_dirty;
    end
    else if (i_set_dirty)
      dirty[i_index] <= 1'b1;
  end

endmodule

// ==== src/riscv_dcache_data.sv ====
`timescale 1ns/1ps

module riscv_dcache_data #(
  parameter int INDEX    = 6,
  parameter int BYTE_OFF = 4
) (
  input  logic                         i_riscv_dcache_clk,
  input  logic                         i_wren,
  input  logic                         i_refill,
  input  logic [INDEX-1:0]             i_index,
  input  logic [BYTE_OFF-1:0]          i_byte_off,
  input  riscv_dcache_pkg::store_size_e i_store_size,
  input  logic [63:0]                  i_wdata,
  input  riscv_dcache_pkg::line_u      i_refill_line,
  output riscv_dcache_pkg::line_u      o_line
);
  import riscv_dcache_pkg::*;

  localparam int NBYTES = LINE_BITS / 8;

  line_u      mem [2**INDEX];
  line_u      merged;
  logic [3:0] nbytes;

  assign o_line = mem[i_index];

  always_comb
  begin
    case (i_store_size)
      SIZE_BYTE: nbytes = 4'd1;
      SIZE_HALF: nbytes = 4'd2;
      SIZE_WORD: nbytes = 4'd4;
      default:   nbytes = 4'd8;
    endcase
  end

  // overlay the low bytes of the store data starting at the offset
  always_comb
  begin
    merged = mem[i_index];
    for (int b = 0; b < 8; b++)
    begin
      if ((b < int'(nbytes)) && (int'(i_byte_off) + b < NBYTES))
        merged.bytes[int'(i_byte_off) + b] = i_wdata[8*b +: 8];
    end
  end

  always_ff @(posedge i_riscv_dcache_clk)
  begin
    if (i_wren)
    begin
      if (i_refill)
        mem[i_index] <= i_refill_line;
      else
        mem[i_index] <= merged;
    end
  end

  // CPU side must never issue a misaligned doubleword store
  a_dword_aligned : assert property (@(posedge i_riscv_dcache_clk)
    (i_wren && !i_refill && i_store_size == SIZE_DWORD) |-> (i_byte_off[2:0] == 3'b000));

endmodule

// ==== src/riscv_dcache_fsm.sv ====
`timescale 1ns/1ps

module riscv_dcache_fsm (
  input  logic                     i_riscv_dcache_clk,
  input  logic                     i_riscv_dcache_rst,
  input  logic                     i_cpu_wren,
  input  logic                     i_cpu_rden,
  input  logic                     i_cpu_amo,
  input  logic                     i_globstall,
  input  logic                     i_hit,
  input  logic                     i_dirty,
  riscv_dcache_mem_if.cache        mem_port,
  output logic                     o_cache_wren,
  output logic [1:0]               o_insel,
  output logic                     o_set_valid,
  output logic                     o_set_dirty,
  output logic                     o_replace_tag,
  output logic                     o_tag_sel,
  output logic                     o_amo_buf_en,
  output logic                     o_amo_en,
  output logic                     o_stall
);
  import riscv_dcache_pkg::*;

  dcache_state_e state;
  dcache_state_e next_state;
  logic          amo_done;
  logic          cpu_req;

  assign cpu_req = i_cpu_wren || i_cpu_rden || i_cpu_amo;

  always_ff @(posedge i_riscv_dcache_clk or posedge i_riscv_dcache_rst)
  begin
    if (i_riscv_dcache_rst)
    begin
      state    <= IDLE;
      amo_done <= 1'b0;
    end
    else
    begin
      state    <= next_state;
      // blocks a second AMO while the finished one is still presented
      amo_done <= (state == AMO_WRITE);
    end
  end

  //////////////////////////////////////////////////
  // next state and outputs
  //////////////////////////////////////////////////
  always_comb
  begin
    next_state        = state;
    o_cache_wren      = 1'b0;
    o_insel           = 2'b00;
    o_set_valid       = 1'b0;
    o_set_dirty       = 1'b0;
    o_replace_tag     = 1'b0;
    o_tag_sel         = 1'b0;
    o_amo_buf_en      = 1'b0;
    o_amo_en          = 1'b0;
    o_stall           = 1'b0;
    mem_port.mem_wren = 1'b0;
    mem_port.mem_rden = 1'b0;
    case (state)
      IDLE:
      begin
        if (!i_globstall && !amo_done && cpu_req)
        begin
          if (!i_hit)
          begin
            o_stall    = 1'b1;
            next_state = i_dirty ? WRITE_BACK : REFILL;
          end
          else if (i_cpu_amo)
          begin
            o_stall    = 1'b1;
            next_state = AMO_READ;
          end
          else if (i_cpu_wren)
          begin
            // store hit
            o_cache_wren = 1'b1;
            o_set_dirty  = 1'b1;
          end
        end
      end
      WRITE_BACK:
      begin
        o_stall           = 1'b1;
        o_tag_sel         = 1'b1;
        mem_port.mem_wren = 1'b1;
        if (mem_port.mem_ready)
          next_state = REFILL;
      end
      REFILL:
      begin
        o_stall           = 1'b1;
        mem_port.mem_rden = 1'b1;
        if (mem_port.mem_ready)
        begin
          o_cache_wren  = 1'b1;
          o_insel       = 2'b01;
          o_replace_tag = 1'b1;
          o_set_valid   = 1'b1;
          next_state    = IDLE;
        end
      end
      AMO_READ:
      begin
        o_stall      = 1'b1;
        o_amo_buf_en = 1'b1;
        next_state   = AMO_WRITE;
      end
      AMO_WRITE:
      begin
        o_stall      = 1'b1;
        o_amo_en     = 1'b1;
        o_insel      = 2'b10;
        o_cache_wren = 1'b1;
        o_set_dirty  = 1'b1;
        next_state   = IDLE;
      end
      default: next_state = IDLE;
    endcase
  end

  // memory answers only while exactly one request is held
  a_mem_onehot : assert property (@(posedge i_riscv_dcache_clk) disable iff (i_riscv_dcache_rst)
    mem_port.mem_ready |-> (mem_port.mem_wren ^ mem_port.mem_rden));

  // refilled line hits back in idle and a plain access then goes through unstalled
  a_hit_no_stall : assert property (@(posedge i_riscv_dcache_clk)
    disable iff (i_riscv_dcache_rst)
    (state == REFILL && mem_port.mem_ready) |=> (i_hit && (i_cpu_amo || !o_stall)));

endmodule

// ==== src/riscv_dcache_amo.sv ====
`timescale 1ns/1ps

module riscv_dcache_amo (
  input  logic                     i_enable,
  input  riscv_dcache_pkg::amo_op_e i_op,
  input  logic                     i_dword,
  input  logic [63:0]              i_rs1,
  input  logic [63:0]              i_rs2,
  output logic [63:0]              o_result
);
  import riscv_dcache_pkg::*;

  logic [63:0] op_a;
  logic [63:0] op_b;
  logic [63:0] raw;
  logic        lt_signed;
  logic        lt_unsigned;

  // word operands sign extended so one comparator serves both widths
  assign op_a = i_dword ? i_rs1 : {{32{i_rs1[31]}}, i_rs1[31:0]};
  assign op_b = i_dword ? i_rs2 : {{32{i_rs2[31]}}, i_rs2[31:0]};

  assign lt_signed   = $signed(op_a) < $signed(op_b);
  assign lt_unsigned = op_a < op_b;

  always_comb
  begin
    case (i_op)
      AMO_ADD:  raw = op_a + op_b;
      AMO_SWAP: raw = op_b;
      AMO_XOR:  raw = op_a ^ op_b;
      AMO_OR:   raw = op_a | op_b;
      AMO_AND:  raw = op_a & op_b;
      AMO_MIN:  raw = lt_signed ? op_a : op_b;
      AMO_MAX:  raw = lt_signed ? op_b : op_a;
      AMO_MINU: raw = lt_unsigned ? op_a : op_b;
      AMO_MAXU: raw = lt_unsigned ? op_b : op_a;
      default:  raw = '0;
    endcase
  end

  always_comb
  begin
    if (!i_enable)
      o_result = '0;
    else if (i_dword)
      o_result = raw;
    else
      o_result = {{32{raw[31]}}, raw[31:0]};
  end

endmodule

// ==== src/riscv_dram.sv ====
`timescale 1ns/1ps

module riscv_dram #(
  parameter int MEM_SIZE    = 16384,
  parameter int MEM_LATENCY = 4,
  parameter int INDEX       = 6,
  parameter int TAG         = 4
) (
  input  logic         i_riscv_dcache_clk,
  input  logic         i_riscv_dcache_rst,
  riscv_dcache_mem_if.memory mem_port
);
  import riscv_dcache_pkg::*;

  localparam int DEPTH = MEM_SIZE / (LINE_BITS / 8);
  localparam int CNT_W = $clog2(MEM_LATENCY + 1);

  logic [LINE_BITS-1:0]   ram [DEPTH];
  logic [CNT_W-1:0]       cnt;
  logic [INDEX+TAG-1:0]   addr;
  logic                   req;
  logic                   last;

  assign addr = mem_port.mem_addr;
  assign req  = mem_port.mem_wren || mem_port.mem_rden;
  assign last = req && !mem_port.mem_ready && (cnt == CNT_W'(MEM_LATENCY - 1));

  initial
  begin
    for (int i = 0; i < DEPTH; i++)
      ram[i] = '0;
  end

  // latency counter, one ready pulse per request
  always_ff @(posedge i_riscv_dcache_clk or posedge i_riscv_dcache_rst)
  begin
    if (i_riscv_dcache_rst)
    begin
      cnt                <= '0;
      mem_port.mem_ready <= 1'b0;
    end
    else if (mem_port.mem_ready)
    begin
      cnt                <= '0;
      mem_port.mem_ready <= 1'b0;
    end
    else if (last)
    begin
      cnt                <= '0;
      mem_port.mem_ready <= 1'b1;
    end
    else if (req)
      cnt <= cnt + 1'b1;
  end

  always_ff @(posedge i_riscv_dcache_clk)
  begin
    if (last && mem_port.mem_rden)
      mem_port.mem_rdata <= ram[addr];
    if (mem_port.mem_ready && mem_port.mem_wren)
      ram[addr] <= mem_port.mem_wdata;
  end

  a_addr_stable : assert property (@(posedge i_riscv_dcache_clk)
    disable iff (i_riscv_dcache_rst)
    (req && !mem_port.mem_ready) |=> (req && $stable(addr)));

endmodule

// ==== src/riscv_data_cache.sv ====
`timescale 1ns/1ps

module riscv_data_cache #(
  parameter int CACHE_SIZE  = 1024,
  parameter int MEM_SIZE    = 16384,
  parameter int MEM_LATENCY = 4
) (
  input  logic                          i_riscv_dcache_clk,
  input  logic                          i_riscv_dcache_rst,
  input  logic                          i_riscv_dcache_globstall,
  input  logic                          i_riscv_dcache_cpu_wren,
  input  logic                          i_riscv_dcache_cpu_rden,
  input  logic                          i_riscv_dcache_amo,
  input  riscv_dcache_pkg::store_size_e i_riscv_dcache_store_src,
  input  riscv_dcache_pkg::amo_op_e     i_riscv_dcache_amo_op,
  input  logic [63:0]                   i_riscv_dcache_phys_addr,
  input  logic [63:0]                   i_riscv_dcache_cpu_data_in,
  output logic [63:0]                   o_riscv_dcache_cpu_data_out,
  output logic                          o_riscv_dcache_cpu_stall
);
  import riscv_dcache_pkg::*;

  localparam int ADDR     = $clog2(MEM_SIZE);
  localparam int BYTE_OFF = $clog2(LINE_BITS / 8);
  localparam int INDEX    = $clog2(CACHE_SIZE / (LINE_BITS / 8));
  localparam int TAG      = ADDR - INDEX - BYTE_OFF;

  logic [TAG-1:0]      tag;
  logic [INDEX-1:0]    index;
  logic [BYTE_OFF-1:0] byte_off;
  // fsm controls
  logic                set_valid;
  logic                set_dirty;
  logic                replace_tag;
  logic                cache_wren;
  logic [1:0]          insel;
  logic                tag_sel;
  logic                amo_buf_en;
  logic                amo_en;
  // tag array status
  logic                hit;
  logic                dirty;
  logic [TAG-1:0]      victim_tag;
  // datapath
  line_u               cache_line;
  logic [63:0]         cache_wdata;
  logic [63:0]         sel_dword;
  logic [63:0]         old_value;
  logic [63:0]         amo_buf;
  logic [63:0]         amo_result;
  logic                amo_dword;

  riscv_dcache_mem_if #(.ADDR_W(TAG + INDEX)) mem_if ();

  assign {tag, index, byte_off} = i_riscv_dcache_phys_addr[ADDR-1:0];

  //////////////////////////////////////////////////
  // memory side
  //////////////////////////////////////////////////
  assign mem_if.mem_addr  = tag_sel ? {victim_tag, index} : {tag, index};
  assign mem_if.mem_wdata = cache_line;

  // word or doubleword data into the line, refill comes in whole
  assign cache_wdata = insel[1] ? amo_result : i_riscv_dcache_cpu_data_in;

  assign amo_dword = (i_riscv_dcache_store_src == SIZE_DWORD);
  assign sel_dword = cache_line.dwords[byte_off[3]];

  // old value of the addressed word, sign extended
  always_comb
  begin
    if (amo_dword)
      old_value = sel_dword;
    else if (byte_off[2])
      old_value = {{32{sel_dword[63]}}, sel_dword[63:32]};
    else
      old_value = {{32{sel_dword[31]}}, sel_dword[31:0]};
  end

  always_ff @(posedge i_riscv_dcache_clk)
  begin
    if (amo_buf_en)
      amo_buf <= old_value;
  end

  assign o_riscv_dcache_cpu_data_out = i_riscv_dcache_amo ? amo_buf : sel_dword;

  //////////////////////////////////////////////////
  // blocks
  //////////////////////////////////////////////////
  riscv_dcache_tag #(
    .INDEX (INDEX),
    .TAG   (TAG)
  ) u_tag (
    .i_riscv_dcache_clk (i_riscv_dcache_clk),
    .i_riscv_dcache_rst (i_riscv_dcache_rst),
    .i_index            (index),
    .i_tag              (tag),
    .i_set_valid        (set_valid),
    .i_set_dirty        (set_dirty),
    .i_replace_tag      (replace_tag),
    .o_hit              (hit),
    .o_dirty            (dirty),
    .o_victim_tag       (victim_tag)
  );

  riscv_dcache_data #(
    .INDEX    (INDEX),
    .BYTE_OFF (BYTE_OFF)
  ) u_data (
    .i_riscv_dcache_clk (i_riscv_dcache_clk),
    .i_wren             (cache_wren),
    .i_refill           (insel[0]),
    .i_index            (index),
    .i_byte_off         (byte_off),
    .i_store_size       (i_riscv_dcache_store_src),
    .i_wdata            (cache_wdata),
    .i_refill_line      (mem_if.mem_rdata),
    .o_line             (cache_line)
  );

  riscv_dcache_fsm u_fsm (
    .i_riscv_dcache_clk (i_riscv_dcache_clk),
    .i_riscv_dcache_rst (i_riscv_dcache_rst),
    .i_cpu_wren         (i_riscv_dcache_cpu_wren),
    .i_cpu_rden         (i_riscv_dcache_cpu_rden),
    .i_cpu_amo          (i_riscv_dcache_amo),
    .i_globstall        (i_riscv_dcache_globstall),
    .i_hit              (hit),
    .i_dirty            (dirty),
    .mem_port           (mem_if.cache),
    .o_cache_wren       (cache_wren),
    .o_insel            (insel),
    .o_set_valid        (set_valid),
    .o_set_dirty        (set_dirty),
    .o_replace_tag      (replace_tag),
    .o_tag_sel          (tag_sel),
    .o_amo_buf_en       (amo_buf_en),
    .o_amo_en           (amo_en),
    .o_stall            (o_riscv_dcache_cpu_stall)
  );

  riscv_dcache_amo u_amo (
    .i_enable (amo_en),
    .i_op     (i_riscv_dcache_amo_op),
    .i_dword  (amo_dword),
    .i_rs1    (amo_buf),
    .i_rs2    (i_riscv_dcache_cpu_data_in),
    .o_result (amo_result)
  );

  riscv_dram #(
    .MEM_SIZE    (MEM_SIZE),
    .MEM_LATENCY (MEM_LATENCY),
    .INDEX       (INDEX),
    .TAG         (TAG)
  ) u_dram (
    .i_riscv_dcache_clk (i_riscv_dcache_clk),
    .i_riscv_dcache_rst (i_riscv_dcache_rst),
    .mem_port           (mem_if.memory)
  );

endmodule

// ==== testbench/riscv_dcache_checker.sv ====
`timescale 1ns/1ps

module riscv_dcache_checker (
  input  logic        i_clk,
  input  logic        i_rst,
  input  logic        i_cpu_wren,
  input  logic        i_cpu_rden,
  input  logic        i_amo,
  input  logic        i_stall,
  input  logic [63:0] i_addr,
  input  logic [63:0] i_data_out,
  input  logic [63:0] i_exp_data,
  input  logic        i_exp_miss,
  input  logic        i_exp_check,
  output int          o_errors,
  output int          o_checks
);

  logic saw_stall;
  logic req;

  assign req = i_cpu_wren || i_cpu_rden || i_amo;

  initial
  begin
    o_errors  = 0;
    o_checks  = 0;
    saw_stall = 1'b0;
  end

  // an access completes at the first edge with the request up and stall down
  always @(posedge i_clk)
  begin
    if (i_rst)
      saw_stall <= 1'b0;
    else if (req && i_stall)
      saw_stall <= 1'b1;
    else if (req)
    begin
      o_checks = o_checks + 1;
      if (i_exp_check && (i_data_out !== i_exp_data))
      begin
        o_errors = o_errors + 1;
        $display("ERR %0t: addr %h returned %h, expected %h",
                 $time, i_addr, i_data_out, i_exp_data);
      end
      // AMOs always stall, so only loads and stores say something about hit or miss
      if (!i_amo && (saw_stall !== i_exp_miss))
      begin
        o_errors = o_errors + 1;
        $display("ERR %0t: addr %h stall %s", $time, i_addr,
                 i_exp_miss ? "did not rise on a miss" : "rose on a hit");
      end
      saw_stall <= 1'b0;
    end
  end

endmodule

// ==== testbench/riscv_dcache_tb.sv ====
`timescale 1ns/1ps

module riscv_dcache_tb;
  import riscv_dcache_pkg::*;

  localparam int TIMEOUT = 200;

  // K_HELD is a store presented under global stall
  typedef enum logic [1:0] {K_LOAD, K_STORE, K_AMO, K_HELD} kind_e;

  typedef struct packed {
    kind_e       kind;
    amo_op_e     op;
    store_size_e size;
    logic [63:0] addr;
    logic [63:0] data;
    logic [63:0] exp;
    logic        miss;
  } entry_t;

  logic        clk = 1'b0;
  logic        rst;
  logic        globstall;
  logic        cpu_wren;
  logic        cpu_rden;
  logic        amo;
  store_size_e store_src;
  amo_op_e     amo_op;
  logic [63:0] phys_addr;
  logic [63:0] data_in;
  logic [63:0] data_out;
  logic        stall;
  logic [63:0] exp_data;
  logic        exp_miss;
  logic        exp_check;
  int          errors;
  int          checks;
  int          tb_errors = 0;
  int          timeouts = 0;
  integer      seed = 34946;
  entry_t      stim_q[$];

  always #4 clk = ~clk;

  riscv_data_cache #(
    .CACHE_SIZE  (1024),
    .MEM_SIZE    (16384),
    .MEM_LATENCY (4)
  ) u_dut (
    .i_riscv_dcache_clk          (clk),
    .i_riscv_dcache_rst          (rst),
    .i_riscv_dcache_globstall    (globstall),
    .i_riscv_dcache_cpu_wren     (cpu_wren),
    .i_riscv_dcache_cpu_rden     (cpu_rden),
    .i_riscv_dcache_amo          (amo),
    .i_riscv_dcache_store_src    (store_src),
    .i_riscv_dcache_amo_op       (amo_op),
    .i_riscv_dcache_phys_addr    (phys_addr),
    .i_riscv_dcache_cpu_data_in  (data_in),
    .o_riscv_dcache_cpu_data_out (data_out),
    .o_riscv_dcache_cpu_stall    (stall)
  );

  riscv_dcache_checker u_checker (
    .i_clk       (clk),
    .i_rst       (rst),
    .i_cpu_wren  (cpu_wren),
    .i_cpu_rden  (cpu_rden),
    .i_amo       (amo),
    .i_stall     (stall),
    .i_addr      (phys_addr),
    .i_data_out  (data_out),
    .i_exp_data  (exp_data),
    .i_exp_miss  (exp_miss),
    .i_exp_check (exp_check),
    .o_errors    (errors),
    .o_checks    (checks)
  );

  //////////////////////////////////////////////////
  // expected values
  //////////////////////////////////////////////////
  // word ops run in the upper half, so carries, signs and unsigned order act as 32 bit
  function automatic logic [63:0] amo_ref(input amo_op_e op, input logic dword,
                                          input logic [63:0] old, input logic [63:0] src);
    logic [63:0] a;
    logic [63:0] b;
    logic [63:0] r;
    a = dword ? old : {old[31:0], 32'h0};
    b = dword ? src : {src[31:0], 32'h0};
    case (op)
      AMO_ADD:  r = a + b;
      AMO_SWAP: r = b;
      AMO_XOR:  r = a ^ b;
      AMO_OR:   r = a | b;
      AMO_AND:  r = a & b;
      AMO_MIN:  r = ($signed(a) < $signed(b)) ? a : b;
      AMO_MAX:  r = ($signed(a) < $signed(b)) ? b : a;
      AMO_MINU: r = (a < b) ? a : b;
      AMO_MAXU: r = (a < b) ? b : a;
      default:  r = 64'h0;
    endcase
    return dword ? r : {{32{r[63]}}, r[63:32]};
  endfunction

  task automatic push_entry(input kind_e kind, input amo_op_e op, input store_size_e size,
                            input logic [63:0] addr, input logic [63:0] data,
                            input logic [63:0] exp, input logic miss);
    stim_q.push_back('{kind, op, size, addr, data, exp, miss});
  endtask

  task automatic build_stimulus();
    amo_op_e     op_list [9] = '{AMO_ADD, AMO_SWAP, AMO_XOR, AMO_OR, AMO_AND,
                                 AMO_MIN, AMO_MAX, AMO_MINU, AMO_MAXU};
    logic [63:0] r0;
    logic [63:0] r1;
    logic [63:0] v_lo;
    logic [63:0] v_hi;
    logic [63:0] src;
    logic [63:0] cur;
    r0   = {$random(seed), $random(seed)};
    r1   = {$random(seed), $random(seed)};
    v_lo = {r0[63:24], r1[7:0], r0[15:0]};
    v_hi = {16'h0, r1[15:0], r0[31:0]};
    // cold line, then merges of every store size into it
    push_entry(K_LOAD,  AMO_ADD, SIZE_DWORD, 64'h0100, 64'h0, 64'h0, 1'b1);
    push_entry(K_STORE, AMO_ADD, SIZE_DWORD, 64'h0100, r0,    64'h0, 1'b0);
    push_entry(K_LOAD,  AMO_ADD, SIZE_DWORD, 64'h0100, 64'h0, r0,    1'b0);
    push_entry(K_STORE, AMO_ADD, SIZE_BYTE,  64'h0102, r1,    64'h0, 1'b0);
    push_entry(K_LOAD,  AMO_ADD, SIZE_DWORD, 64'h0100, 64'h0, v_lo,  1'b0);
    push_entry(K_STORE, AMO_ADD, SIZE_HALF,  64'h010c, r1,    64'h0, 1'b0);
    push_entry(K_STORE, AMO_ADD, SIZE_WORD,  64'h0108, r0,    64'h0, 1'b0);
    push_entry(K_LOAD,  AMO_ADD, SIZE_DWORD, 64'h010c, 64'h0, v_hi,  1'b0);
    // same index, other tag, so the dirty line goes out and comes back
    push_entry(K_LOAD,  AMO_ADD, SIZE_DWORD, 64'h0500, 64'h0, 64'h0, 1'b1);
    push_entry(K_LOAD,  AMO_ADD, SIZE_DWORD, 64'h0100, 64'h0, v_lo,  1'b1);
    push_entry(K_LOAD,  AMO_ADD, SIZE_DWORD, 64'h0108, 64'h0, v_hi,  1'b0);
    // doubleword AMO chain, each one returns the previous result
    cur = {$random(seed), $random(seed)};
    push_entry(K_STORE, AMO_ADD, SIZE_DWORD, 64'h0200, cur, 64'h0, 1'b1);
    foreach (op_list[i])
    begin
      src = {$random(seed), $random(seed)};
      push_entry(K_AMO, op_list[i], SIZE_DWORD, 64'h0200, src, cur, 1'b0);
      cur = amo_ref(op_list[i], 1'b1, cur, src);
    end
    push_entry(K_LOAD, AMO_ADD, SIZE_DWORD, 64'h0200, 64'h0, cur, 1'b0);
    // word chain in the upper word of the upper doubleword
    src = {$random(seed), $random(seed)};
    push_entry(K_STORE, AMO_ADD, SIZE_WORD, 64'h020c, src, 64'h0, 1'b0);
    cur = {{32{src[31]}}, src[31:0]};
    foreach (op_list[i])
    begin
      src = {$random(seed), $random(seed)};
      push_entry(K_AMO, op_list[i], SIZE_WORD, 64'h020c, src, cur, 1'b0);
      cur = amo_ref(op_list[i], 1'b0, cur, src);
    end
    push_entry(K_LOAD, AMO_ADD, SIZE_DWORD, 64'h0208, 64'h0, {cur[31:0], 32'h0}, 1'b0);
    // store under global stall must leave the line alone
    push_entry(K_HELD, AMO_ADD, SIZE_DWORD, 64'h0100, ~r0,  64'h0, 1'b0);
    push_entry(K_LOAD, AMO_ADD, SIZE_DWORD, 64'h0100, 64'h0, v_lo, 1'b0);
  endtask

  //////////////////////////////////////////////////
  // stimulus loop
  //////////////////////////////////////////////////
  initial
  begin
    entry_t e;
    int     cycles;
    rst       = 1'b1;
    globstall = 1'b0;
    cpu_wren  = 1'b0;
    cpu_rden  = 1'b0;
    amo       = 1'b0;
    store_src = SIZE_DWORD;
    amo_op    = AMO_ADD;
    phys_addr = 64'h0;
    data_in   = 64'h0;
    exp_data  = 64'h0;
    exp_miss  = 1'b0;
    exp_check = 1'b0;
    build_stimulus();
    repeat (2) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);
    if (stall !== 1'b0)
    begin
      tb_errors++;
      $display("ERR %0t: stall is %b after reset", $time, stall);
    end
    for (int i = 0; i < stim_q.size(); i++)
    begin
      e = stim_q[i];
      cpu_wren  <= (e.kind == K_STORE) || (e.kind == K_HELD);
      cpu_rden  <= (e.kind == K_LOAD);
      amo       <= (e.kind == K_AMO);
      globstall <= (e.kind == K_HELD);
      amo_op    <= e.op;
      store_src <= e.size;
      phys_addr <= e.addr;
      data_in   <= e.data;
      exp_data  <= e.exp;
      exp_miss  <= e.miss;
      exp_check <= (e.kind == K_LOAD) || (e.kind == K_AMO);
      cycles = 0;
      @(posedge clk);
      while (stall && cycles < TIMEOUT)
      begin
        @(posedge clk);
        cycles++;
      end
      if (stall)
      begin
        timeouts++;
        $display("timeout: stall still high %0d cycles into entry %0d", TIMEOUT, i);
        break;
      end
      cpu_wren  <= 1'b0;
      cpu_rden  <= 1'b0;
      amo       <= 1'b0;
      globstall <= 1'b0;
      @(posedge clk);
    end
    $display("checks %0d, errors %0d, timeouts %0d", checks, errors + tb_errors, timeouts);
    if (errors + tb_errors + timeouts == 0)
      $display("Simulation completed successfully");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

// ==== project.f ====
src/riscv_dcache_pkg.sv
src/riscv_dcache_mem_if.sv
src/riscv_dcache_tag.sv
src/riscv_dcache_data.sv
src/riscv_dcache_fsm.sv
src/riscv_dcache_amo.sv
src/riscv_dram.sv
src/riscv_data_cache.sv
testbench/riscv_dcache_checker.sv
testbench/riscv_dcache_tb.sv

// ==== Bender.yml ====
package:
  name: riscv_dcache

sources:
  - files:
      - src/riscv_dcache_pkg.sv
      - src/riscv_dcache_mem_if.sv
      - src/riscv_dcache_tag.sv
      - src/riscv_dcache_data.sv
      - src/riscv_dcache_fsm.sv
      - src/riscv_dcache_amo.sv
      - src/riscv_dram.sv
      - src/riscv_data_cache.sv
  - target: test
    files:
      - testbench/riscv_dcache_checker.sv
      - testbench/riscv_dcache_tb.sv
